// File: all.f
+incdir+test
design/riscv_pkg.sv
design/mem_rw.sv
design/data_mem.sv
design/wb_regfile.sv
design/mem_wb_top.sv
test/tb_mem_wb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the MEM/WB testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_wb -f all.f -o tb_mem_wb \
    > build.log 2>&1 \
    && ./obj_dir/tb_mem_wb > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL: no verdict"; exit 1; }
echo "PASS"

// File: test/mem_wb_model.svh
// testbench model: shadow memory and registers, expected WB stage, load and store lane rules
`ifndef MEM_WB_MODEL_SVH
`define MEM_WB_MODEL_SVH

logic [31:0]                  shadow_mem [riscv_pkg::DMEM_WORDS];
logic [31:0]                  shadow_regs [riscv_pkg::NUM_REGS];

// instruction expected in WB, one edge behind the inputs
logic                         exp_wb_write;
logic [riscv_pkg::REG_AW-1:0] exp_wb_rd;
logic [31:0]                  exp_wb_data;
logic                         exp_wb_trap;

function automatic logic is_load(riscv_pkg::mem_oper_t op);
    return op inside {riscv_pkg::MEM_LB, riscv_pkg::MEM_LBU, riscv_pkg::MEM_LH,
                      riscv_pkg::MEM_LHU, riscv_pkg::MEM_LW};
endfunction

function automatic logic is_store(riscv_pkg::mem_oper_t op);
    return op inside {riscv_pkg::MEM_SB, riscv_pkg::MEM_SH, riscv_pkg::MEM_SW};
endfunction

// lane moved down to bit 0, then sign or zero extended
function automatic logic [31:0] extract_load(riscv_pkg::mem_oper_t op, logic [31:0] word,
                                             logic [1:0] offs);
    logic [31:0] lane;
    lane = word >> (8 * offs);
    case (op)
        riscv_pkg::MEM_LB:  return {{24{lane[7]}}, lane[7:0]};
        riscv_pkg::MEM_LBU: return {24'd0, lane[7:0]};
        riscv_pkg::MEM_LH:  return {{16{lane[15]}}, lane[15:0]};
        riscv_pkg::MEM_LHU: return {16'd0, lane[15:0]};
        default:            return word;
    endcase
endfunction

function automatic logic [31:0] merge_store(riscv_pkg::mem_oper_t op, logic [31:0] old,
                                            logic [31:0] data, logic [1:0] offs);
    logic [31:0] mask;
    if (op == riscv_pkg::MEM_SB)
        mask = 32'h0000_00ff;
    else if (op == riscv_pkg::MEM_SH)
        mask = 32'h0000_ffff;
    else
        mask = 32'hffff_ffff;
    mask = mask << (8 * offs);
    return (old & ~mask) | ((data << (8 * offs)) & mask);
endfunction

task automatic model_reset();
    foreach (shadow_regs[i])
        shadow_regs[i] = '0;
    {exp_wb_write, exp_wb_rd, exp_wb_data, exp_wb_trap} = '0;
endtask

// one rising edge: the WB instruction retires, the current one moves into WB
task automatic model_edge();
    logic [riscv_pkg::DMEM_AW-1:0] idx;
    idx = alu_result[riscv_pkg::DMEM_AW+1:2];
    if (exp_wb_write && !exp_wb_trap && (exp_wb_rd != '0))
        shadow_regs[exp_wb_rd] = exp_wb_data;
    exp_wb_write = write_rd;
    exp_wb_rd    = rd_addr;
    exp_wb_trap  = trap_in;
    exp_wb_data  = wb_use_mem ? extract_load(mem_oper, shadow_mem[idx], alu_result[1:0])
                              : alu_result;
    if (is_store(mem_oper))
        shadow_mem[idx] = merge_store(mem_oper, shadow_mem[idx], alu_oper2, alu_result[1:0]);
endtask

`endif

// File: test/tb_mem_wb.sv
// testbench for mem_wb_top: clock, reset, random instruction stream, model checks, timeout
`timescale 1ns/10ps

module tb_mem_wb;

    // 1327 stimulus cycles plus margin
    localparam int cycle_limit = 1400;

    logic                         clk;
    logic                         rstn;
    logic [31:0]                  alu_result;
    logic [31:0]                  alu_oper2;
    riscv_pkg::mem_oper_t         mem_oper;
    logic                         trap_in;
    logic                         wb_use_mem;
    logic                         write_rd;
    logic [riscv_pkg::REG_AW-1:0] rd_addr;
    logic [riscv_pkg::REG_AW-1:0] dbg_addr;
    logic [31:0]                  dbg_data;
    logic                         trap_out;

    // rd of the last two instructions, to aim the debug port at fresh writes
    logic [riscv_pkg::REG_AW-1:0] rd_prev1;
    logic [riscv_pkg::REG_AW-1:0] rd_prev2;
    int                           errors;
    int                           checks;
    int                           cycle_cnt = 0;

    `include "mem_wb_model.svh"

    mem_wb_top dut0
    (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .alu_result_i (alu_result),
        .alu_oper2_i  (alu_oper2),
        .mem_oper_i   (mem_oper),
        .trap_i       (trap_in),
        .wb_use_mem_i (wb_use_mem),
        .write_rd_i   (write_rd),
        .rd_addr_i    (rd_addr),
        .dbg_addr_i   (dbg_addr),
        .dbg_data_o   (dbg_data),
        .trap_o       (trap_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // aligned address inside a 64-word window at 0x200
    function automatic logic [31:0] window_addr(riscv_pkg::mem_oper_t op);
        logic [31:0] offs;
        offs = 32'($urandom_range(3));
        if (op inside {riscv_pkg::MEM_LH, riscv_pkg::MEM_LHU, riscv_pkg::MEM_SH})
            offs = offs & 32'd2;
        else if (op inside {riscv_pkg::MEM_LW, riscv_pkg::MEM_SW})
            offs = 32'd0;
        return 32'h200 + 32'($urandom_range(63)) * 32'd4 + offs;
    endfunction

    function automatic logic [riscv_pkg::REG_AW-1:0] pick_dbg();
        return ($urandom_range(1) == 1) ? rd_prev2 : 5'($urandom_range(31));
    endfunction

    task automatic check_outputs();
        checks += 2;
        if (dbg_data !== shadow_regs[dbg_addr])
        begin
            errors++;
            $display("[ERROR] %0d ns dbg_data_o (x%0d) expected %h got %h", $time, dbg_addr,
                     shadow_regs[dbg_addr], dbg_data);
        end
        if (trap_out !== exp_wb_trap)
        begin
            errors++;
            $display("[ERROR] %0d ns trap_o expected %b got %b", $time, exp_wb_trap, trap_out);
        end
    endtask

    // drive one instruction, check mid-cycle, advance the model at the edge
    task automatic apply(input riscv_pkg::mem_oper_t op, input logic [31:0] alu,
                         input logic [31:0] oper2, input logic trap, input logic wr,
                         input logic [4:0] rd, input logic [4:0] dbg);
        mem_oper   = op;
        alu_result = alu;
        alu_oper2  = oper2;
        trap_in    = trap;
        wb_use_mem = is_load(op);
        write_rd   = wr;
        rd_addr    = rd;
        dbg_addr   = dbg;
        rd_prev2   = rd_prev1;
        rd_prev1   = rd;
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        model_edge();
        #2;
    endtask

    task automatic random_mixed();
        riscv_pkg::mem_oper_t op;
        logic                 trap;
        op   = riscv_pkg::mem_oper_t'(4'($urandom_range(8)));
        trap = !is_store(op) && ($urandom_range(15) == 0);
        apply(op, (op == riscv_pkg::MEM_NOP) ? $urandom() : window_addr(op), $urandom(), trap,
              $urandom_range(7) != 0, 5'($urandom_range(31)), pick_dbg());
    endtask

    initial
    begin
        logic [31:0] addr;
        void'($urandom(66));
        errors     = 0;
        checks     = 0;
        rd_prev1   = '0;
        rd_prev2   = '0;
        rstn       = 1'b0;
        alu_result = '0;
        alu_oper2  = '0;
        mem_oper   = riscv_pkg::MEM_NOP;
        trap_in    = 1'b0;
        wb_use_mem = 1'b0;
        write_rd   = 1'b0;
        rd_addr    = '0;
        dbg_addr   = '0;
        model_reset();
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;

        // every register cleared by reset
        for (int i = 0; i < riscv_pkg::NUM_REGS; i++)
            apply(riscv_pkg::MEM_NOP, '0, '0, 1'b0, 1'b0, 5'd0, 5'(i));

        // word fill of the whole window first, then random words, then read back
        for (int i = 0; i < 300; i++)
            apply(riscv_pkg::MEM_SW, (i < 64) ? 32'h200 + 32'(4 * i)
                  : window_addr(riscv_pkg::MEM_SW), $urandom(), 1'b0, 1'b0, 5'd0, pick_dbg());
        for (int i = 0; i < 64; i++)
            apply(riscv_pkg::MEM_LW, 32'h200 + 32'(4 * i), '0, 1'b0, 1'b1,
                  5'($urandom_range(31)), pick_dbg());

        // halfword then byte store at each lane offset, then the four narrow loads
        for (int i = 0; i < 16; i++)
        begin
            addr = window_addr(riscv_pkg::MEM_SW) + 32'(i % 4);
            apply(riscv_pkg::MEM_SH, addr & ~32'd1, $urandom(), 1'b0, 1'b0, 5'd0, pick_dbg());
            apply(riscv_pkg::MEM_SB, addr, $urandom(), 1'b0, 1'b0, 5'd0, pick_dbg());
            apply(riscv_pkg::MEM_LB, addr, '0, 1'b0, 1'b1, 5'($urandom_range(31, 1)), pick_dbg());
            apply(riscv_pkg::MEM_LBU, addr, '0, 1'b0, 1'b1, 5'($urandom_range(31, 1)), pick_dbg());
            apply(riscv_pkg::MEM_LH, addr & ~32'd1, '0, 1'b0, 1'b1, 5'($urandom_range(31, 1)),
                  pick_dbg());
            apply(riscv_pkg::MEM_LHU, addr & ~32'd1, '0, 1'b0, 1'b1, 5'($urandom_range(31, 1)),
                  pick_dbg());
        end

        // ALU write-backs, the first aimed at x0, each target read two edges later
        for (int i = 0; i < 20; i++)
            apply(riscv_pkg::MEM_NOP, $urandom(), '0, 1'b0, 1'b1,
                  (i == 0) ? 5'd0 : 5'($urandom_range(31)), rd_prev2);

        // trapped write-backs on every other cycle, targets read back as above
        for (int i = 0; i < 12; i++)
            apply(riscv_pkg::MEM_NOP, $urandom(), '0, (i % 2) == 0, 1'b1,
                  5'($urandom_range(31, 1)), rd_prev2);

        repeat (800) random_mixed();

        // drain the last two instructions
        repeat (3) apply(riscv_pkg::MEM_NOP, '0, '0, 1'b0, 1'b0, 5'd0, pick_dbg());

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule : tb_mem_wb

// File: design/mem_wb_top.sv
// top level: memory-access stage, data memory and write-back register file

`timescale 1ns/10ps

module mem_wb_top
(
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic [31:0]                  alu_result_i,
    input  logic [31:0]                  alu_oper2_i,
    input  riscv_pkg::mem_oper_t         mem_oper_i,
    input  logic                         trap_i,
    input  logic                         wb_use_mem_i,
    input  logic                         write_rd_i,
    input  logic [riscv_pkg::REG_AW-1:0] rd_addr_i,
    input  logic [riscv_pkg::REG_AW-1:0] dbg_addr_i,
    output logic [31:0]                  dbg_data_o,
    output logic                         trap_o
);

    // stage to memory
    logic [31:0]                  rw_addr;
    logic                         read;
    logic [3:0]                   wsel_byte;
    logic [31:0]                  wdata;
    logic [31:0]                  rdata;

    // MEM/WB bundle
    logic                         wb_use_mem;
    logic                         write_rd;
    logic [riscv_pkg::REG_AW-1:0] rd_addr;
    logic [31:0]                  alu_result;
    logic [31:0]                  dmem_rdata;

    mem_rw u_mem_rw
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rw_addr_o    (rw_addr),
        .read_o       (read),
        .wsel_byte_o  (wsel_byte),
        .wdata_o      (wdata),
        .rdata_i      (rdata),
        .alu_result_i (alu_result_i),
        .alu_oper2_i  (alu_oper2_i),
        .mem_oper_i   (mem_oper_i),
        .trap_i       (trap_i),
        .wb_use_mem_i (wb_use_mem_i),
        .write_rd_i   (write_rd_i),
        .rd_addr_i    (rd_addr_i),
        .wb_use_mem_o (wb_use_mem),
        .write_rd_o   (write_rd),
        .rd_addr_o    (rd_addr),
        .alu_result_o (alu_result),
        .dmem_rdata_o (dmem_rdata),
        .trap_o       (trap_o)
    );

    data_mem u_data_mem
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .addr_i      (rw_addr),
        .read_i      (read),
        .wsel_byte_i (wsel_byte),
        .wdata_i     (wdata),
        .rdata_o     (rdata)
    );

    // trap_o doubles as the WB-stage trap that blocks the write
    wb_regfile u_wb_regfile
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .wb_use_mem_i (wb_use_mem),
        .write_rd_i   (write_rd),
        .rd_addr_i    (rd_addr),
        .alu_result_i (alu_result),
        .dmem_rdata_i (dmem_rdata),
        .trap_i       (trap_o),
        .dbg_addr_i   (dbg_addr_i),
        .dbg_data_o   (dbg_data_o)
    );

endmodule : mem_wb_top

// File: design/wb_regfile.sv
// write-back source select and 32-entry register file with debug read port

`timescale 1ns/10ps

module wb_regfile
(
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         wb_use_mem_i,
    input  logic                         write_rd_i,
    input  logic [riscv_pkg::REG_AW-1:0] rd_addr_i,
    input  logic [31:0]                  alu_result_i,
    input  logic [31:0]                  dmem_rdata_i,
    input  logic                         trap_i,
    input  logic [riscv_pkg::REG_AW-1:0] dbg_addr_i,
    output logic [31:0]                  dbg_data_o
);

    logic [31:0] regs [riscv_pkg::NUM_REGS];
    logic [31:0] wb_data;
    logic        wb_en;

    // loaded word or ALU result
    assign wb_data = wb_use_mem_i ? dmem_rdata_i : alu_result_i;

    // trapped instructions retire without touching rd
    assign wb_en = write_rd_i && !trap_i && (rd_addr_i != '0);

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int i = 0; i < riscv_pkg::NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_en)
        begin
            regs[rd_addr_i] <= wb_data;
        end
    end

    // x0 stays zero through reset and the write guard
    assign dbg_data_o = regs[dbg_addr_i];

    a_x0_zero : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (dbg_addr_i == '0) |-> (dbg_data_o == 32'd0))
        else $error("wb_regfile: x0 read back nonzero");

endmodule : wb_regfile

// File: design/data_mem.sv
// byte-addressed data memory, combinational read and byte-enabled write

`timescale 1ns/10ps

module data_mem
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic [31:0] addr_i,
    input  logic        read_i,
    input  logic [3:0]  wsel_byte_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o
);

    logic [31:0]                     mem [riscv_pkg::DMEM_WORDS];
    logic [riscv_pkg::DMEM_AW-1:0]   word_idx;

    // word index from address bits above the byte offset
    assign word_idx = addr_i[riscv_pkg::DMEM_AW+1:2];

    // read data only presented while a load is active
    assign rdata_o = read_i ? mem[word_idx] : '0;

    // each enabled lane written at the edge
    always_ff @(posedge clk_i)
    begin
        for (int lane = 0; lane < 4; lane++)
        begin
            if (wsel_byte_i[lane])
            begin
                mem[word_idx][8*lane +: 8] <= wdata_i[8*lane +: 8];
            end
        end
    end

    // accesses must stay inside the array, upper bits are otherwise dropped
    a_addr_in_range : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (read_i || (wsel_byte_i != 4'b0000))
            |-> (addr_i < 32'(4 * riscv_pkg::DMEM_WORDS)))
        else $error("data_mem: access outside memory at %h", addr_i);

endmodule : data_mem

// File: design/mem_rw.sv
// memory-access stage: load lane extraction, store lane steering, MEM/WB registers

`timescale 1ns/10ps

module mem_rw
(
    input  logic                        clk_i,
    input  logic                        rstn_i,

    // data memory side
    output logic [31:0]                 rw_addr_o,
    output logic                        read_o,
    output logic [3:0]                  wsel_byte_o,
    output logic [31:0]                 wdata_o,
    input  logic [31:0]                 rdata_i,

    // EX/MEM bundle
    input  logic [31:0]                 alu_result_i,
    input  logic [31:0]                 alu_oper2_i,
    input  riscv_pkg::mem_oper_t        mem_oper_i,
    input  logic                        trap_i,
    input  logic                        wb_use_mem_i,
    input  logic                        write_rd_i,
    input  logic [riscv_pkg::REG_AW-1:0] rd_addr_i,

    // MEM/WB bundle
    output logic                        wb_use_mem_o,
    output logic                        write_rd_o,
    output logic [riscv_pkg::REG_AW-1:0] rd_addr_o,
    output logic [31:0]                 alu_result_o,
    output logic [31:0]                 dmem_rdata_o,
    output logic                        trap_o
);

    logic [31:0] load_data;
    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // read level from the load decode, separate from the store lane case
    assign read_o = mem_oper_i inside {riscv_pkg::MEM_LB, riscv_pkg::MEM_LBU, riscv_pkg::MEM_LH,
                                       riscv_pkg::MEM_LHU, riscv_pkg::MEM_LW};

    // address only leaves the stage while memory is accessed
    assign rw_addr_o = (read_o || (wsel_byte_o != 4'b0000)) ? alu_result_i : '0;

    // lane picked by the low address bits, no alignment check
    always_comb
    begin
        case (alu_result_i[1:0])
            2'b00:   load_byte = rdata_i[7:0];
            2'b01:   load_byte = rdata_i[15:8];
            2'b10:   load_byte = rdata_i[23:16];
            default: load_byte = rdata_i[31:24];
        endcase
        load_half = alu_result_i[1] ? rdata_i[31:16] : rdata_i[15:0];
    end

    always_comb
    begin
        load_data   = '0;
        wsel_byte_o = 4'b0000;
        wdata_o     = '0;

        case (mem_oper_i)
            riscv_pkg::MEM_LB:
            begin
                load_data = {{24{load_byte[7]}}, load_byte};
            end
            riscv_pkg::MEM_LBU:
            begin
                load_data = {24'd0, load_byte};
            end
            riscv_pkg::MEM_LH:
            begin
                load_data = {{16{load_half[15]}}, load_half};
            end
            riscv_pkg::MEM_LHU:
            begin
                load_data = {16'd0, load_half};
            end
            riscv_pkg::MEM_LW:
            begin
                load_data = rdata_i;
            end
            // stores shift operand and mask into the addressed lane
            riscv_pkg::MEM_SB:
            begin
                wsel_byte_o = 4'b0001 << alu_result_i[1:0];
                wdata_o     = alu_oper2_i << {alu_result_i[1:0], 3'b000};
            end
            riscv_pkg::MEM_SH:
            begin
                wsel_byte_o = 4'b0011 << {alu_result_i[1], 1'b0};
                wdata_o     = alu_oper2_i << {alu_result_i[1], 4'b0000};
            end
            riscv_pkg::MEM_SW:
            begin
                wsel_byte_o = 4'b1111;
                wdata_o     = alu_oper2_i;
            end
            default:
            begin
            end
        endcase
    end

    // MEM/WB pipeline registers
    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wb_use_mem_o <= 1'b0;
            write_rd_o   <= 1'b0;
            rd_addr_o    <= '0;
            alu_result_o <= '0;
            dmem_rdata_o <= '0;
            trap_o       <= 1'b0;
        end
        else
        begin
            wb_use_mem_o <= wb_use_mem_i;
            write_rd_o   <= write_rd_i;
            rd_addr_o    <= rd_addr_i;
            alu_result_o <= alu_result_i;
            dmem_rdata_o <= load_data;
            trap_o       <= trap_i;
        end
    end

    // a memory cycle is either a read or a write, never both
    a_no_read_and_write : assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(read_o && (wsel_byte_o != 4'b0000)))
        else $error("mem_rw: read and write strobes active together");

    a_nop_addr_zero : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mem_oper_i == riscv_pkg::MEM_NOP) |-> (rw_addr_o == 32'd0))
        else $error("mem_rw: address driven during MEM_NOP");

endmodule : mem_rw

// File: design/riscv_pkg.sv
// shared memory-operation type and size constants for the MEM/WB back end

package riscv_pkg;

    // memory operation carried down from EX/MEM
    typedef enum logic [3:0]
    {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LBU = 4'd2,
        MEM_LH  = 4'd3,
        MEM_LHU = 4'd4,
        MEM_LW  = 4'd5,
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_oper_t;

    // data memory geometry, 32-bit words
    localparam int DMEM_WORDS = 256;

    // word index width, log2 of DMEM_WORDS
    localparam int DMEM_AW = 8;

    // architectural register file
    localparam int NUM_REGS = 32;

    // register address width
    localparam int REG_AW = 5;

endpackage : riscv_pkg
